/* list.f */
rtl/lsu_pkg.sv
rtl/lsu_load_port.sv
rtl/lsu_store_port.sv
rtl/lsu_commit.sv
rtl/lsu_sram.sv
rtl/lsu_top.sv
sim/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps -f list.f --top-module lsu_tb -o lsu_sim &&
./obj_dir/lsu_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* sim/lsu_cases.txt */
// op funct3 base offset wdata exp_rdata exp_status
// op 0 load 1 store, status 0 okay 1 misaligned 2 bus_error, op ff ends the list
1 2 00000100 00000000 12345678 00000000 0
0 2 00000100 00000000 00000000 12345678 0
1 2 00000000 00000000 cafef00d 00000000 0
0 2 fffffffc 00000004 00000000 cafef00d 0
1 2 00000140 00000000 00000000 00000000 0
1 0 00000140 00000000 ffffff81 00000000 0
1 0 00000140 00000001 0000007f 00000000 0
1 0 00000140 00000002 123456c3 00000000 0
1 0 00000143 00000000 00000004 00000000 0
0 2 00000140 00000000 00000000 04c37f81 0
0 0 00000140 00000000 00000000 ffffff81 0
0 4 00000140 00000000 00000000 00000081 0
0 0 00000141 00000000 00000000 0000007f 0
0 0 00000142 00000000 00000000 ffffffc3 0
0 4 00000140 00000003 00000000 00000004 0
1 2 00000180 00000000 11223344 00000000 0
1 1 00000180 00000000 dead8001 00000000 0
1 1 00000180 00000002 0000f00d 00000000 0
0 1 00000180 00000000 00000000 ffff8001 0
0 5 00000182 00000000 00000000 0000f00d 0
0 1 00000182 00000000 00000000 fffff00d 0
0 2 00000180 00000000 00000000 f00d8001 0
0 1 00000181 00000000 00000000 00000000 1
0 2 00000182 00000000 00000000 00000000 1
1 2 00000181 00000000 ffffffff 00000000 1
0 2 00000180 00000000 00000000 f00d8001 0
0 2 00000400 00000000 00000000 00000000 2
1 2 00000400 00000000 00000055 00000000 2
0 2 00000000 00000000 00000000 cafef00d 0
1 0 000003ff 00000000 0000009a 00000000 0
0 4 000003fc 00000003 00000000 0000009a 0
0 0 00000400 000003ff 00000000 00000000 2
ff 0 00000000 00000000 00000000 00000000 0

/* sim/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

	import lsu_pkg::*;

	localparam int max_cases = 64;
	localparam int fields = 7;
	localparam int wait_limit = 200;

	logic     clock;
	logic     reset;
	logic     req_valid;
	mem_req_t req;
	logic     req_ready;
	logic     rsp_valid;
	mem_rsp_t rsp;
	logic     rsp_ready;

	logic [31:0] case_words [max_cases*fields];
	int          errors;
	int          timeouts;
	int          sent;
	int          answered;
	int          pending;
	logic        held;
	mem_rsp_t    held_rsp;

	lsu_top #(
		.mem_words(256)
	) uut (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.rsp_ready(rsp_ready)
	);

	always #4 clock = ~clock;

	// consumer back-pressure
	initial begin
		rsp_ready = 1'b0;
		void'($urandom(32'hc5c5_1b43));
		forever begin
			@(posedge clock);
			if (reset)
				rsp_ready <= 1'b0;
			else
				rsp_ready <= ($urandom % 3) != 0;
		end
	end

	// response hold, one response per request
	always @(posedge clock) begin
		if (!reset) begin
			if (held && !rsp_valid) begin
				$display("ERROR rsp_valid got 0x0 expected 0x1 while the response waits");
				errors++;
			end else if (held && rsp !== held_rsp) begin
				$display("ERROR rsp got 0x%09h expected 0x%09h while the response waits",
					rsp, held_rsp);
				errors++;
			end
			if (req_valid && req_ready) begin
				if (pending != 0) begin
					$display("a new request was accepted while a response was still owed");
					errors++;
				end
				pending++;
				sent++;
			end
			if (rsp_valid && rsp_ready) begin
				if (pending == 0) begin
					$display("a response was handed over with no request in flight");
					errors++;
				end else begin
					pending--;
				end
				answered++;
			end
			held = rsp_valid && !rsp_ready;
			held_rsp = rsp;
		end
	end

	task automatic check_data(input int idx, input mem_rsp_t got, input logic [31:0] exp);
		if (got.rdata !== exp) begin
			$display("ERROR case %0d: rsp.rdata got 0x%08h expected 0x%08h",
				idx, got.rdata, exp);
			errors++;
		end
	endtask

	task automatic check_status(input int idx, input lsu_status_e got, input lsu_status_e exp);
		if (got !== exp) begin
			$display("ERROR case %0d: rsp.status got 0x%0h expected 0x%0h", idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// returns on the edge where the request transfers
	task automatic issue_request(input mem_req_t r, output bit ok);
		int n;
		n = 0;
		req_valid <= 1'b1;
		req <= r;
		@(posedge clock);
		while (!req_ready && n < wait_limit) begin
			@(posedge clock);
			n++;
		end
		ok = req_ready;
		req_valid <= 1'b0;
	endtask

	task automatic collect_response(output mem_rsp_t got, output bit ok);
		int n;
		n = 0;
		@(posedge clock);
		while (!(rsp_valid && rsp_ready) && n < wait_limit) begin
			@(posedge clock);
			n++;
		end
		ok = rsp_valid && rsp_ready;
		got = rsp;
	endtask

	initial begin
		mem_req_t r;
		mem_rsp_t got;
		bit       ok;
		int       idx;
		int       w;
		clock = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		errors = 0;
		timeouts = 0;
		sent = 0;
		answered = 0;
		pending = 0;
		held = 1'b0;
		held_rsp = '0;
		$readmemh("sim/lsu_cases.txt", case_words);
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_flag("rsp_valid", rsp_valid, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
		ok = 1'b1;
		idx = 0;
		while (ok && idx < max_cases && case_words[idx*fields] != 32'hff) begin
			w = idx * fields;
			r.op = lsu_op_e'(case_words[w][0]);
			r.funct3 = case_words[w+1][2:0];
			r.base = case_words[w+2];
			r.offset = case_words[w+3];
			r.wdata = case_words[w+4];
			issue_request(r, ok);
			if (!ok) begin
				$display("timeout: case %0d was never accepted", idx);
				timeouts++;
			end else begin
				collect_response(got, ok);
				if (!ok) begin
					$display("timeout: case %0d got no response", idx);
					timeouts++;
				end else begin
					check_data(idx, got, case_words[w+5]);
					check_status(idx, got.status, lsu_status_e'(case_words[w+6][1:0]));
				end
			end
			idx++;
		end
		@(posedge clock);
		if (idx == 0) begin
			$display("no cases were read from the case file");
			errors++;
		end
		if (timeouts == 0 && (sent != idx || answered != idx)) begin
			$display("count mismatch: %0d cases, %0d requests accepted, %0d responses taken",
				idx, sent, answered);
			errors++;
		end
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int mem_words = 1024
) (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 req_valid,
	input  lsu_pkg::mem_req_t         req,
	output logic                      req_ready,
	output logic                      rsp_valid,
	output lsu_pkg::mem_rsp_t         rsp,
	input  wire logic                 rsp_ready
);

	import lsu_pkg::*;

	logic        load_start;
	logic        store_start;
	logic [31:0] addr;
	logic [2:0]  funct3;
	logic [31:0] wdata;
	logic        load_done;
	logic        store_done;
	port_done_t  load_result;
	port_done_t  store_result;

	// axi4-lite between the ports and the memory
	logic    ar_valid, ar_ready, r_valid, r_ready;
	logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
	axi_ar_t ar;
	axi_r_t  r;
	axi_aw_t aw;
	axi_w_t  w;
	axi_b_t  b;

	lsu_commit u_commit (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
		.load_start(load_start), .store_start(store_start),
		.addr(addr), .funct3(funct3), .wdata(wdata),
		.load_done(load_done), .load_result(load_result),
		.store_done(store_done), .store_result(store_result)
	);

	lsu_load_port u_load (
		.clock(clock), .reset(reset),
		.start(load_start), .addr(addr), .funct3(funct3),
		.ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
		.r_valid(r_valid), .r(r), .r_ready(r_ready),
		.done(load_done), .result(load_result)
	);

	lsu_store_port u_store (
		.clock(clock), .reset(reset),
		.start(store_start), .addr(addr), .funct3(funct3), .wdata(wdata),
		.aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
		.w_valid(w_valid), .w(w), .w_ready(w_ready),
		.b_valid(b_valid), .b(b), .b_ready(b_ready),
		.done(store_done), .result(store_result)
	);

	lsu_sram #(
		.mem_words(mem_words)
	) u_sram (
		.clock(clock), .reset(reset),
		.ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
		.r_valid(r_valid), .r(r), .r_ready(r_ready),
		.aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
		.w_valid(w_valid), .w(w), .w_ready(w_ready),
		.b_valid(b_valid), .b(b), .b_ready(b_ready)
	);

endmodule

`default_nettype wire

/* rtl/lsu_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_sram #(
	parameter int mem_words = 1024
) (
	input  wire logic                 clock,
	input  wire logic                 reset,

	input  wire logic                 ar_valid,
	input  lsu_pkg::axi_ar_t          ar,
	output logic                      ar_ready,
	output logic                      r_valid,
	output lsu_pkg::axi_r_t           r,
	input  wire logic                 r_ready,

	input  wire logic                 aw_valid,
	input  lsu_pkg::axi_aw_t          aw,
	output logic                      aw_ready,
	input  wire logic                 w_valid,
	input  lsu_pkg::axi_w_t           w,
	output logic                      w_ready,
	output logic                      b_valid,
	output lsu_pkg::axi_b_t           b,
	input  wire logic                 b_ready
);

	import lsu_pkg::*;

	localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
	localparam logic [31:0] addr_limit = 32'(mem_words * 4);

	logic [31:0]      mem [mem_words];
	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] wr_idx;
	logic             rd_ok;
	logic             wr_ok;
	logic             ar_fire;
	logic             wr_fire;

	assign rd_idx = ar.addr[idx_w+1:2];
	assign wr_idx = aw.addr[idx_w+1:2];
	assign rd_ok = (ar.addr < addr_limit);
	assign wr_ok = (aw.addr < addr_limit);

	// a new read only once the previous beat has gone
	assign ar_ready = !r_valid || r_ready;
	assign ar_fire = ar_valid && ar_ready;

	// aw and w taken together
	assign aw_ready = aw_valid && w_valid && (!b_valid || b_ready);
	assign w_ready = aw_ready;
	assign wr_fire = aw_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (ar_fire) begin
			r_valid <= 1'b1;
		end else if (r_valid && r_ready) begin
			r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			r.data <= rd_ok ? mem[rd_idx] : 32'h0;
			r.resp <= rd_ok ? resp_okay : resp_slverr;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			b_valid <= 1'b0;
		end else if (wr_fire) begin
			b_valid <= 1'b1;
		end else if (b_valid && b_ready) begin
			b_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			b.resp <= wr_ok ? resp_okay : resp_slverr;
		end
	end

	// byte lanes under strobe
	always_ff @(posedge clock) begin
		if (wr_fire && wr_ok) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

	// a waiting beat is not replaced by a later read
	a_no_ar_while_r: assert property (@(posedge clock) disable iff (reset)
		r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

`default_nettype wire

/* rtl/lsu_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_commit (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 req_valid,
	input  lsu_pkg::mem_req_t         req,
	output logic                      req_ready,
	output logic                      rsp_valid,
	output lsu_pkg::mem_rsp_t         rsp,
	input  wire logic                 rsp_ready,
	output logic                      load_start,
	output logic                      store_start,
	output logic [31:0]               addr,
	output logic [2:0]                funct3,
	output logic [31:0]               wdata,
	input  wire logic                 load_done,
	input  lsu_pkg::port_done_t       load_result,
	input  wire logic                 store_done,
	input  lsu_pkg::port_done_t       store_result
);

	import lsu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_hold
	} state_e;

	state_e     state;
	lsu_op_e    op_q;
	logic       accept;
	logic       is_misaligned;
	logic       port_done;
	port_done_t port_result;

	assign addr = req.base + req.offset;
	assign funct3 = req.funct3;
	assign wdata = req.wdata;

	// half needs bit 0 clear, word needs bits 1:0 clear
	assign is_misaligned = (funct3[1:0] == 2'b01 && addr[0]) ||
		(funct3[1:0] == 2'b10 && addr[1:0] != 2'b00);

	assign req_ready = (state == st_idle);
	assign rsp_valid = (state == st_hold);
	assign accept = req_valid && req_ready;
	assign load_start = accept && !is_misaligned && req.op == lsu_load;
	assign store_start = accept && !is_misaligned && req.op == lsu_store;

	assign port_done = (op_q == lsu_store) ? store_done : load_done;
	assign port_result = (op_q == lsu_store) ? store_result : load_result;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (accept) state <= is_misaligned ? st_hold : st_busy;
				st_busy: if (port_done) state <= st_hold;
				st_hold: if (rsp_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q <= req.op;
			rsp.rdata <= 32'h0;
			rsp.status <= misaligned;
		end else if (state == st_busy && port_done) begin
			rsp.rdata <= (op_q == lsu_store) ? 32'h0 : port_result.rdata;
			rsp.status <= port_result.bus_err ? bus_error : okay;
		end
	end

	// a port only completes the access that was dispatched to it
	a_load_done_busy: assert property (@(posedge clock) disable iff (reset)
		load_done |-> state == st_busy && op_q == lsu_load);

	a_store_done_busy: assert property (@(posedge clock) disable iff (reset)
		store_done |-> state == st_busy && op_q == lsu_store);

endmodule

`default_nettype wire

/* rtl/lsu_store_port.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_port (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 start,
	input  wire logic [31:0]          addr,
	input  wire logic [2:0]           funct3,
	input  wire logic [31:0]          wdata,
	output logic                      aw_valid,
	output lsu_pkg::axi_aw_t          aw,
	input  wire logic                 aw_ready,
	output logic                      w_valid,
	output lsu_pkg::axi_w_t           w,
	input  wire logic                 w_ready,
	input  wire logic                 b_valid,
	input  lsu_pkg::axi_b_t           b,
	output logic                      b_ready,
	output logic                      done,
	output lsu_pkg::port_done_t       result
);

	import lsu_pkg::*;

	logic       b_wait;
	logic [3:0] mask;

	// sb, sh, sw
	always_comb begin
		case (funct3[1:0])
			2'b00: mask = 4'b0001;
			2'b01: mask = 4'b0011;
			default: mask = 4'b1111;
		endcase
	end

	// aw and w drop on their own handshakes
	always_ff @(posedge clock) begin
		if (reset) begin
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
			b_wait <= 1'b0;
		end else if (start) begin
			aw_valid <= 1'b1;
			w_valid <= 1'b1;
			b_wait <= 1'b1;
		end else begin
			if (aw_valid && aw_ready)
				aw_valid <= 1'b0;
			if (w_valid && w_ready)
				w_valid <= 1'b0;
			if (b_valid && b_ready && b_wait)
				b_wait <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			aw.addr <= addr;
			aw.size <= {1'b0, funct3[1:0]};
			w.data <= wdata << {addr[1:0], 3'b000};
			w.strb <= mask << addr[1:0];
		end
	end

	assign b_ready = 1'b1;
	assign done = b_valid && b_ready && b_wait;
	assign result.rdata = 32'h0;
	assign result.bus_err = (b.resp != resp_okay);

	a_b_after_aw_w: assert property (@(posedge clock) disable iff (reset)
		b_valid |-> !aw_valid && !w_valid);

endmodule

`default_nettype wire

/* rtl/lsu_load_port.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_port (
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire logic                 start,
	input  wire logic [31:0]          addr,
	input  wire logic [2:0]           funct3,
	output logic                      ar_valid,
	output lsu_pkg::axi_ar_t          ar,
	input  wire logic                 ar_ready,
	input  wire logic                 r_valid,
	input  lsu_pkg::axi_r_t           r,
	output logic                      r_ready,
	output logic                      done,
	output lsu_pkg::port_done_t       result
);

	import lsu_pkg::*;

	logic        r_wait;
	logic [2:0]  funct3_q;
	logic [31:0] shifted;
	logic [31:0] ext;

	// valid and response wait
	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid <= 1'b0;
			r_wait <= 1'b0;
		end else begin
			if (start) begin
				ar_valid <= 1'b1;
				r_wait <= 1'b1;
			end else if (ar_valid && ar_ready) begin
				ar_valid <= 1'b0;
			end
			if (r_valid && r_ready && r_wait) begin
				r_wait <= 1'b0;
			end
		end
	end

	// request payload, held until the R beat
	always_ff @(posedge clock) begin
		if (start) begin
			ar.addr <= addr;
			ar.size <= {1'b0, funct3[1:0]};
			funct3_q <= funct3;
		end
	end

	assign r_ready = 1'b1;

	// bring the addressed byte lane down to bit 0
	assign shifted = r.data >> {ar.addr[1:0], 3'b000};

	always_comb begin
		case (funct3_q)
			3'b000: ext = {{24{shifted[7]}}, shifted[7:0]};
			3'b001: ext = {{16{shifted[15]}}, shifted[15:0]};
			3'b010: ext = shifted;
			3'b100: ext = {24'h0, shifted[7:0]};
			3'b101: ext = {16'h0, shifted[15:0]};
			default: ext = 32'h0;
		endcase
	end

	assign done = r_valid && r_ready && r_wait;
	assign result.rdata = ext;
	assign result.bus_err = (r.resp != resp_okay);

	a_ar_stable: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	typedef enum logic {
		lsu_load  = 1'b0,
		lsu_store = 1'b1
	} lsu_op_e;

	typedef enum logic [1:0] {
		okay       = 2'd0,
		misaligned = 2'd1,
		bus_error  = 2'd2
	} lsu_status_e;

	// axi response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		lsu_op_e     op;
		logic [2:0]  funct3;
		logic [31:0] base;
		logic [31:0] offset;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		lsu_status_e status;
	} mem_rsp_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	// completion from a channel port
	typedef struct packed {
		logic [31:0] rdata;
		logic        bus_err;
	} port_done_t;

endpackage

`default_nettype wire
